//--- src/dram_pkg.sv
// memory sizes, timing localparams, access enums and request/response structs
package dram_pkg;

    localparam int MEM_WORDS        = 1024;  // 32-bit words in the array
    localparam int MEM_AW           = 10;    // word index width
    localparam int MEM_LAT          = 3;     // accept to rvalid, in cycles
    localparam int REFRESH_INTERVAL = 200;
    localparam int REFRESH_LAT      = 8;
    localparam int CNT_W            = 8;     // width of the controller counters

    // bit 2 marks the unsigned loads, bits 1:0 give the size
    typedef enum logic [2:0] {
        LSU_B  = 3'b000,
        LSU_H  = 3'b001,
        LSU_W  = 3'b010,
        LSU_BU = 3'b100,
        LSU_HU = 3'b101
    } lsu_size_e;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
        lsu_size_e   psize;   // sideband, size and signedness
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        mem_op_e           op;
        logic [MEM_AW-1:0] widx;
        logic [31:0]       wdata;
        logic [3:0]        mask;  // one bit per byte lane
        logic              last;  // final word of the apb transfer
    } mem_req_t;

    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

//--- src/unaligned_access.sv
// unaligned_access, apb slave that splits byte/half/word accesses into masked word requests
module unaligned_access (
    input  logic               clk,
    input  logic               i_rst_n,
    input  dram_pkg::apb_req_t i_apb,
    output dram_pkg::apb_rsp_t o_apb,
    output logic               o_req_valid,
    output dram_pkg::mem_req_t o_req,
    input  logic               i_req_ready,
    input  dram_pkg::mem_rsp_t i_rsp
);
    import dram_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FIRST,
        S_WAIT1,
        S_SECOND,
        S_WAIT2,
        S_DONE
    } state_e;

    state_e            state;
    logic              r_err;
    logic [31:0]       r_word0;   // word at the access address
    logic [31:0]       r_word1;   // following word of a split load

    logic [1:0]        off;
    logic [3:0]        base_mask;
    logic [1:0]        span;      // access bytes minus one
    logic [7:0]        mask8;
    logic [63:0]       wdata64;
    logic [63:0]       rdata64;
    logic [31:0]       ld_raw;
    logic [32:0]       end_addr;
    logic              split;
    logic              range_err;
    logic [MEM_AW-1:0] widx0;

    assign off = i_apb.paddr[1:0];

    always_comb begin
        case (i_apb.psize)
            LSU_B, LSU_BU: begin
                base_mask = 4'b0001;
                span      = 2'd0;
            end
            LSU_H, LSU_HU: begin
                base_mask = 4'b0011;
                span      = 2'd1;
            end
            default: begin
                base_mask = 4'b1111;
                span      = 2'd3;
            end
        endcase
    end

    // lanes above 3 belong to the next word
    assign mask8     = {4'b0000, base_mask} << off;
    assign wdata64   = {32'h0, i_apb.pwdata} << {off, 3'b000};
    assign split     = |mask8[7:4];
    assign widx0     = i_apb.paddr[MEM_AW+1:2];

    // every byte touched has to lie inside the array
    assign end_addr  = {1'b0, i_apb.paddr} + {31'h0, span};
    assign range_err = end_addr >= 33'(4 * MEM_WORDS);

    assign o_req_valid = (state == S_FIRST) || (state == S_SECOND);

    always_comb begin
        o_req.op = i_apb.pwrite ? MEM_WRITE : MEM_READ;
        if (state == S_SECOND) begin
            o_req.widx  = widx0 + MEM_AW'(1);
            o_req.wdata = wdata64[63:32];  // remaining bytes shifted down
            o_req.mask  = mask8[7:4];
            o_req.last  = 1'b1;
        end else begin
            o_req.widx  = widx0;
            o_req.wdata = wdata64[31:0];
            o_req.mask  = mask8[3:0];
            o_req.last  = !split;
        end
    end

    // merge both words, then pick the addressed bytes
    assign rdata64 = {r_word1, r_word0} >> {off, 3'b000};
    assign ld_raw  = rdata64[31:0];

    always_comb begin
        o_apb.pready  = (state == S_DONE);
        o_apb.pslverr = (state == S_DONE) && r_err;
        case (i_apb.psize)
            LSU_B:   o_apb.prdata = {{24{ld_raw[7]}}, ld_raw[7:0]};
            LSU_BU:  o_apb.prdata = {24'h0, ld_raw[7:0]};
            LSU_H:   o_apb.prdata = {{16{ld_raw[15]}}, ld_raw[15:0]};
            LSU_HU:  o_apb.prdata = {16'h0, ld_raw[15:0]};
            default: o_apb.prdata = ld_raw;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
            r_err <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_apb.psel && i_apb.penable) begin  // access phase
                        r_err <= range_err;
                        state <= range_err ? S_DONE : S_FIRST;
                    end
                end
                S_FIRST: begin
                    if (i_req_ready) begin
                        state <= S_WAIT1;
                    end
                end
                S_WAIT1: begin
                    if (i_rsp.rvalid) begin
                        state <= split ? S_SECOND : S_DONE;
                    end
                end
                S_SECOND: begin
                    if (i_req_ready) begin
                        state <= S_WAIT2;
                    end
                end
                S_WAIT2: begin
                    if (i_rsp.rvalid) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;  // S_DONE, one cycle of pready
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rsp.rvalid && state == S_WAIT1) begin
            r_word0 <= i_rsp.rdata;
        end
        if (i_rsp.rvalid && state == S_WAIT2) begin
            r_word1 <= i_rsp.rdata;
        end
    end

endmodule

//--- src/mem_arbiter.sv
// mem_arbiter, two-port round-robin word request arbiter with a lock for split accesses
module mem_arbiter (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic [1:0]         i_req_valid,
    input  dram_pkg::mem_req_t i_req [2],
    output logic [1:0]         o_req_ready,
    output dram_pkg::mem_rsp_t o_rsp [2],
    output logic               o_mem_valid,
    output dram_pkg::mem_req_t o_mem_req,
    input  logic               i_mem_ready,
    input  dram_pkg::mem_rsp_t i_mem_rsp
);

    logic r_prio;       // port favored in the next open round
    logic r_lock;       // split access in progress
    logic r_owner;      // port of the outstanding request
    logic r_pend_last;  // outstanding request ends its transfer
    logic gnt;
    logic gnt_valid;
    logic accept;

    always_comb begin
        if (r_lock) begin
            gnt = r_owner;
        end else if (i_req_valid[r_prio]) begin
            gnt = r_prio;
        end else begin
            gnt = !r_prio;
        end
        gnt_valid = i_req_valid[gnt];
    end

    assign o_mem_valid = gnt_valid;
    assign o_mem_req   = i_req[gnt];
    assign accept      = gnt_valid && i_mem_ready;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_req_ready[i]  = i_mem_ready && (gnt == 1'(i));
            o_rsp[i].rvalid = i_mem_rsp.rvalid && (r_owner == 1'(i));  // owner only
            o_rsp[i].rdata  = i_mem_rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_prio      <= 1'b0;
            r_lock      <= 1'b0;
            r_owner     <= 1'b0;
            r_pend_last <= 1'b0;
        end else begin
            if (accept) begin
                r_owner     <= gnt;
                r_prio      <= !gnt;
                r_pend_last <= o_mem_req.last;
            end
            // a new first half wins over the release of the previous owner
            if (accept && !o_mem_req.last) begin
                r_lock <= 1'b1;
            end else if (i_mem_rsp.rvalid && r_pend_last) begin
                r_lock <= 1'b0;
            end
        end
    end

endmodule

//--- src/word_mem_ctrl.sv
// word_mem_ctrl, byte-masked word memory with fixed latency and periodic refresh
module word_mem_ctrl (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_req_valid,
    input  dram_pkg::mem_req_t i_req,
    output logic               o_req_ready,
    output dram_pkg::mem_rsp_t o_rsp
);
    import dram_pkg::*;

    logic [31:0]      r_mem [MEM_WORDS];
    logic [31:0]      r_rdata;
    logic             r_rvalid;
    logic [CNT_W-1:0] r_busy_cnt;   // cycles left of the current access
    logic [CNT_W-1:0] r_ref_cnt;    // refresh interval counter
    logic [CNT_W-1:0] r_ref_left;   // cycles left of the current refresh
    logic             r_ref_pend;   // interval expired while busy
    logic             ref_expire;
    logic             ref_req;
    logic             idle;
    logic             accept;

    assign ref_expire   = (r_ref_cnt == CNT_W'(REFRESH_INTERVAL - 1));
    assign ref_req      = ref_expire || r_ref_pend;
    assign idle         = (r_busy_cnt == '0) && (r_ref_left == '0);
    assign o_req_ready  = idle && !ref_req;
    assign accept       = i_req_valid && o_req_ready;
    assign o_rsp.rvalid = r_rvalid;
    assign o_rsp.rdata  = r_rdata;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_busy_cnt <= '0;
            r_rvalid   <= 1'b0;
            r_ref_cnt  <= '0;
            r_ref_left <= '0;
            r_ref_pend <= 1'b0;
        end else begin
            r_rvalid <= (r_busy_cnt == CNT_W'(1));  // lands MEM_LAT after accept
            if (accept) begin
                r_busy_cnt <= CNT_W'(MEM_LAT - 1);
            end else if (r_busy_cnt != '0) begin
                r_busy_cnt <= r_busy_cnt - 1'b1;
            end

            r_ref_cnt <= ref_expire ? '0 : r_ref_cnt + 1'b1;

            // the start cycle already counts as the first refresh cycle
            if (ref_req && idle) begin
                r_ref_left <= CNT_W'(REFRESH_LAT - 1);
                r_ref_pend <= 1'b0;
            end else begin
                if (r_ref_left != '0) begin
                    r_ref_left <= r_ref_left - 1'b1;
                end
                if (ref_expire) begin
                    r_ref_pend <= 1'b1;
                end
            end
        end
    end

    // old word is read on every accept, writes then touch only masked lanes
    always_ff @(posedge clk) begin
        if (accept) begin
            r_rdata <= r_mem[i_req.widx];
            if (i_req.op == MEM_WRITE) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_req.mask[b]) begin
                        r_mem[i_req.widx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- src/dram_subsys.sv
// dram_subsys, two apb adapters sharing one word memory controller through an arbiter
module dram_subsys (
    input  logic               clk,
    input  logic               i_rst_n,
    input  dram_pkg::apb_req_t i_apb0,
    output dram_pkg::apb_rsp_t o_apb0,
    input  dram_pkg::apb_req_t i_apb1,
    output dram_pkg::apb_rsp_t o_apb1
);
    import dram_pkg::*;

    logic [1:0] req_valid;
    logic [1:0] req_ready;
    mem_req_t   req [2];      // adapter side, index is the port
    mem_rsp_t   rsp [2];
    logic       mem_valid;
    logic       mem_ready;
    mem_req_t   mem_req;      // controller side
    mem_rsp_t   mem_rsp;

    unaligned_access u_ua0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_apb       (i_apb0),
        .o_apb       (o_apb0),
        .o_req_valid (req_valid[0]),
        .o_req       (req[0]),
        .i_req_ready (req_ready[0]),
        .i_rsp       (rsp[0])
    );

    unaligned_access u_ua1 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_apb       (i_apb1),
        .o_apb       (o_apb1),
        .o_req_valid (req_valid[1]),
        .o_req       (req[1]),
        .i_req_ready (req_ready[1]),
        .i_rsp       (rsp[1])
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_req_ready (req_ready),
        .o_rsp       (rsp),
        .o_mem_valid (mem_valid),
        .o_mem_req   (mem_req),
        .i_mem_ready (mem_ready),
        .i_mem_rsp   (mem_rsp)
    );

    word_mem_ctrl u_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (mem_valid),
        .i_req       (mem_req),
        .o_req_ready (mem_ready),
        .o_rsp       (mem_rsp)
    );

endmodule

//--- dv/tb_ref_model.svh
// reference byte memory with size decode, range check, store and load model functions
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [7:0] ref_mem [4 * MEM_WORDS];  // byte image of the word array, little endian

function automatic int ref_bytes(input lsu_size_e size);
    case (size)
        LSU_B, LSU_BU: return 1;
        LSU_H, LSU_HU: return 2;
        default:       return 4;
    endcase
endfunction

// every byte of the access has to sit below 4 * MEM_WORDS
function automatic bit ref_in_range(input logic [31:0] addr, input lsu_size_e size);
    return (64'(addr) + 64'(ref_bytes(size))) <= 64'(4 * MEM_WORDS);
endfunction

function automatic void ref_store(input logic [31:0] addr, input lsu_size_e size,
                                  input logic [31:0] data);
    for (int i = 0; i < ref_bytes(size); i++) begin
        ref_mem[int'(addr) + i] = data[8*i +: 8];  // low byte goes to the lowest address
    end
endfunction

function automatic logic [31:0] ref_load(input logic [31:0] addr, input lsu_size_e size);
    logic [31:0] raw;
    raw = '0;
    for (int i = 0; i < ref_bytes(size); i++) begin
        raw[8*i +: 8] = ref_mem[int'(addr) + i];
    end
    case (size)
        LSU_B:   return {{24{raw[7]}}, raw[7:0]};
        LSU_H:   return {{16{raw[15]}}, raw[15:0]};
        default: return raw;  // unsigned and word loads, upper bytes already zero
    endcase
endfunction

`endif

//--- dv/tb_dram_subsys.sv
// testbench for dram_subsys with clock, reset, two apb drivers, reference checks and timeouts
module tb_dram_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import dram_pkg::*;

    `include "tb_ref_model.svh"

    localparam int TIMEOUT = 300;   // cycles allowed for one pready
    localparam int REGION  = 1024;  // bytes owned by each port

    typedef enum logic [2:0] {
        T_WORD_RW, T_BYTE_HALF, T_CROSS, T_RANDOM, T_REFRESH_LONG, T_RANGE_ERR
    } test_e;

    typedef struct packed {
        test_e    test;
        logic     chk_data;  // loads inside the array only
        apb_rsp_t rsp;
    } exp_t;

    logic      clk = 1'b0;
    logic      i_rst_n = 1'b0;
    apb_req_t  apb0 = '0;
    apb_req_t  apb1 = '0;
    apb_rsp_t  rsp0;
    apb_rsp_t  rsp1;
    exp_t      exp_q0 [$];
    exp_t      exp_q1 [$];
    test_e     cur_test [2];
    lsu_size_e kinds [5] = '{LSU_B, LSU_H, LSU_W, LSU_BU, LSU_HU};
    int        checks = 0;

    dram_subsys DUT (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_apb0  (apb0),
        .o_apb0  (rsp0),
        .i_apb1  (apb1),
        .o_apb1  (rsp1)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rdata(input string name, input int p, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("error: test %s port %0d prdata expected %h actual %h",
                                name, p, exp, act));
        end
    endtask

    task automatic check_err(input string name, input int p, input apb_rsp_t exp,
                             input apb_rsp_t act);
        if (act.pslverr !== exp.pslverr) begin
            abort_run($sformatf("error: test %s port %0d pslverr expected %b actual %b",
                                name, p, exp.pslverr, act.pslverr));
        end
    endtask

    task automatic check_port(input int p, input apb_rsp_t act);
        exp_t e;
        if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
            abort_run($sformatf("port %0d gave pready with no transfer open", p));
        end else begin
            e = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
            check_err(e.test.name(), p, e.rsp, act);
            if (e.chk_data) begin
                check_rdata(e.test.name(), p, e.rsp.prdata, act.prdata);
            end
            checks++;
        end
    endtask

    always @(posedge clk) begin  // compare on every pready
        if (i_rst_n) begin
            if (rsp0.pready) begin
                check_port(0, rsp0);
            end
            if (rsp1.pready) begin
                check_port(1, rsp1);
            end
        end
    end

    task automatic drive(input int p, input apb_req_t req);
        if (p == 0) begin
            apb0 <= req;
        end else begin
            apb1 <= req;
        end
    endtask

    task automatic apb_xfer(input int p, input bit wr, input logic [31:0] addr,
                            input lsu_size_e size, input logic [31:0] wdata);
        apb_req_t req;
        apb_rsp_t rsp;
        exp_t     e;
        int       waited;
        e.test     = cur_test[p];
        e.chk_data = !wr && ref_in_range(addr, size);
        e.rsp      = '{pready: 1'b1, prdata: '0, pslverr: !ref_in_range(addr, size)};
        if (e.chk_data) begin
            e.rsp.prdata = ref_load(addr, size);
        end
        if (wr && ref_in_range(addr, size)) begin
            ref_store(addr, size, wdata);
        end
        if (p == 0) begin
            exp_q0.push_back(e);
        end else begin
            exp_q1.push_back(e);
        end
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata, psize: size};
        @(posedge clk);
        drive(p, req);  // setup phase
        @(posedge clk);
        req.penable = 1'b1;
        drive(p, req);
        waited = 0;
        do begin
            @(posedge clk);
            rsp = (p == 0) ? rsp0 : rsp1;
            waited++;
            if (!rsp.pready && waited > TIMEOUT) begin
                abort_run($sformatf("port %0d got no pready within %0d cycles in test %s",
                                    p, TIMEOUT, cur_test[p].name()));
            end
        end while (!rsp.pready);
        req.psel    = 1'b0;
        req.penable = 1'b0;
        drive(p, req);
    endtask

    function automatic lsu_size_e rand_size();
        return kinds[$urandom % 5];
    endfunction

    task automatic run_port(input int p);
        logic [31:0] base;
        logic [31:0] a;
        base = (p == 0) ? 32'h0 : 32'h800;  // disjoint regions
        cur_test[p] = T_WORD_RW;
        for (int w = 0; w < REGION; w += 4) begin
            apb_xfer(p, 1'b1, base + w, LSU_W, $urandom);
        end
        for (int w = 0; w < REGION; w += 4) begin
            apb_xfer(p, 1'b0, base + w, LSU_W, '0);
        end
        cur_test[p] = T_BYTE_HALF;
        for (int w = 0; w < 32; w += 4) begin
            for (int o = 0; o < 4; o++) begin
                apb_xfer(p, 1'b1, base + w + o, LSU_B, $urandom);
                apb_xfer(p, 1'b0, base + w, LSU_W, '0);
            end
            for (int o = 0; o < 3; o++) begin  // halfwords inside one word
                apb_xfer(p, 1'b1, base + w + o, LSU_H, $urandom);
                apb_xfer(p, 1'b0, base + w, LSU_W, '0);
            end
        end
        cur_test[p] = T_CROSS;
        for (int w = 64; w < 128; w += 8) begin
            apb_xfer(p, 1'b1, base + w + 3, LSU_H, $urandom);
            apb_xfer(p, 1'b1, base + w + 5 + (w / 8) % 3, LSU_W, $urandom);
            for (int o = 0; o < 8; o++) begin
                for (int k = 0; k < 5; k++) begin
                    apb_xfer(p, 1'b0, base + w + o, kinds[k], '0);
                end
            end
        end
        cur_test[p] = T_RANDOM;
        for (int i = 0; i < 300; i++) begin
            a = base + $urandom % (REGION - 3);
            apb_xfer(p, 1'($urandom), a, rand_size(), $urandom);
        end
        cur_test[p] = T_REFRESH_LONG;  // about sixty refresh intervals
        for (int i = 0; i < 1500; i++) begin
            a = base + $urandom % (REGION - 3);
            apb_xfer(p, 1'($urandom), a, rand_size(), $urandom);
        end
        for (int w = 0; w < REGION; w += 4) begin
            apb_xfer(p, 1'b0, base + w, LSU_W, '0);
        end
        cur_test[p] = T_RANGE_ERR;
        for (int i = 0; i < 8; i++) begin
            a = 32'h1000 + base + 4 * i + $urandom % 4;  // low bits alias the own region
            apb_xfer(p, 1'b1, a, rand_size(), $urandom);
            apb_xfer(p, 1'b0, a, rand_size(), '0);
            apb_xfer(p, 1'b0, base + 4 * i, LSU_W, '0);
        end
        apb_xfer(p, 1'b1, 32'hffff_fffc, LSU_W, $urandom);
        apb_xfer(p, 1'b0, base, LSU_W, '0);
    endtask

    initial begin
        void'($urandom(32'hf033_b373));
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
        fork
            run_port(0);
            run_port(1);
        join
        repeat (2) @(posedge clk);
        if (exp_q0.size() == 0 && exp_q1.size() == 0) begin
            $display("%0d transfers checked", checks);
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("transfers were left without a response at the end of the run");
        end
    end

endmodule

//--- filelist.f
+incdir+dv
src/dram_pkg.sv
src/unaligned_access.sv
src/mem_arbiter.sv
src/word_mem_ctrl.sv
src/dram_subsys.sv
dv/tb_dram_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dram_subsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary -Wno-fatal --top-module tb_dram_subsys -f filelist.f -Mdir obj_dir; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dram_subsys 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^ALL CHECKS PASSED$' <<< "$output"; then
    exit 0
fi
echo "pass message not found"
exit 1
